// File: all.f
src/nand_pkg.sv
src/nand_write_cycle.sv
src/nand_read_cycle.sv
src/nand_busy_wait.sv
src/nand_sequencer.sv
src/nand_controller.sv
testbench/nand_flash_model.sv
testbench/tb_nand_controller.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_nand_controller \
        -f all.f -o sim_nand

./obj_dir/sim_nand | tee sim.log

if grep -q '^=== PASS ===$' sim.log; then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi

// File: src/nand_busy_wait.sv
`timescale 1ns/1ps

module nand_busy_wait #(
        parameter nand_pkg::tick_cnt_t t_wb = nand_pkg::DEF_T_WB
) (
        input  logic clk,
        input  logic counter_rst,
        input  logic go,
        input  logic r,         // ready/busy, high is ready
        output logic ack
);
        import nand_pkg::*;

        typedef enum logic [1:0] {bw_idle, bw_delay, bw_ready} bw_state_e;

        bw_state_e phase;
        tick_cnt_t cnt;

        always_ff @(posedge clk) begin
                if (counter_rst) begin
                        phase <= bw_idle;
                        cnt   <= '0;
                        ack   <= 1'b0;
                end else begin
                        ack <= 1'b0;
                        case (phase)
                        bw_idle: if (go) begin
                                phase <= bw_delay;
                                cnt   <= 8'd1;
                        end
                        bw_delay: begin         // r is not valid yet
                                cnt <= cnt + 8'd1;
                                if (cnt >= t_wb)
                                        phase <= bw_ready;
                        end
                        default: if (r) begin
                                ack   <= 1'b1;
                                phase <= bw_idle;
                        end
                        endcase
                end
        end

        a_ack_ready: assert property (@(posedge clk) disable iff (counter_rst)
                ack |-> r);

endmodule

// File: src/nand_controller.sv
`timescale 1ns/1ps

module nand_controller #(
        parameter nand_pkg::tick_cnt_t t_wp  = nand_pkg::DEF_T_WP,
        parameter nand_pkg::tick_cnt_t t_wc  = nand_pkg::DEF_T_WC,
        parameter nand_pkg::tick_cnt_t t_rp  = nand_pkg::DEF_T_RP,
        parameter nand_pkg::tick_cnt_t t_reh = nand_pkg::DEF_T_REH,
        parameter nand_pkg::tick_cnt_t t_wb  = nand_pkg::DEF_T_WB
) (
        input  logic                 clk,
        input  logic                 counter_rst,
        input  nand_pkg::nfcr_t      nfcr,
        input  nand_pkg::row_addr_t  nf_addr,
        input  logic                 r,
        input  nand_pkg::nand_byte_t read_flash,
        output logic                 done,
        output nand_pkg::nand_byte_t status,
        output nand_pkg::flash_id_t  id,
        output nand_pkg::nand_pins_t pins,
        output nand_pkg::nand_byte_t write_flash,
        output logic                 read_flash_en
);
        import nand_pkg::*;

        nand_byte_t wr_byte, rd_byte;
        logic       wr_go, wr_ack, wr_is_cmd, wr_is_addr, wr_last_addr;
        logic       rd_go, rd_ack, busy_go, busy_ack;
        logic       cle, ale, ce_n, re_n, we_n;

        assign pins = '{cle: cle, ale: ale, ce_n: ce_n, re_n: re_n, we_n: we_n};

        nand_sequencer seq_inst (
                .clk(clk), .counter_rst(counter_rst),
                .nfcr(nfcr), .nf_addr(nf_addr),
                .done(done), .status(status), .id(id),
                .read_flash_en(read_flash_en), .ce_n(ce_n),
                .wr_go(wr_go), .wr_byte(wr_byte), .wr_is_cmd(wr_is_cmd),
                .wr_is_addr(wr_is_addr), .wr_last_addr(wr_last_addr), .wr_ack(wr_ack),
                .rd_go(rd_go), .rd_ack(rd_ack), .rd_byte(rd_byte),
                .busy_go(busy_go), .busy_ack(busy_ack)
        );

        nand_write_cycle #(.t_wp(t_wp), .t_wc(t_wc)) wr_inst (
                .clk(clk), .counter_rst(counter_rst),
                .go(wr_go), .byte_in(wr_byte), .is_cmd(wr_is_cmd),
                .is_addr(wr_is_addr), .last_addr(wr_last_addr),
                .ack(wr_ack), .cle(cle), .ale(ale), .we_n(we_n),
                .write_flash(write_flash)
        );

        nand_read_cycle #(.t_rp(t_rp), .t_reh(t_reh)) rd_inst (
                .clk(clk), .counter_rst(counter_rst),
                .go(rd_go), .read_flash(read_flash),
                .ack(rd_ack), .data(rd_byte), .re_n(re_n)
        );

        nand_busy_wait #(.t_wb(t_wb)) busy_inst (
                .clk(clk), .counter_rst(counter_rst),
                .go(busy_go), .r(r), .ack(busy_ack)
        );

endmodule

// File: src/nand_pkg.sv
package nand_pkg;

        typedef logic [7:0]  nand_byte_t;       // one byte on the flash io bus
        typedef logic [31:0] row_addr_t;
        typedef logic [39:0] flash_id_t;        // first id byte in the top bits
        typedef logic [7:0]  tick_cnt_t;        // strobe and busy delay counts

        //////////////////////////////////////////////////
        // control byte fields
        //////////////////////////////////////////////////

        typedef enum logic [3:0] {
                op_none        = 4'd0,
                op_program     = 4'd1,  // not supported
                op_page_read   = 4'd2,  // not supported
                op_erase       = 4'd3,
                op_reset       = 4'd4,
                op_read_id     = 4'd5,
                op_read_status = 4'd6
        } nand_op_e;

        typedef enum logic [1:0] {
                ps_256  = 2'd0,
                ps_512  = 2'd1,
                ps_1k   = 2'd2,
                ps_2k   = 2'd3          // large page address layout
        } page_size_e;

        typedef struct packed {
                logic       start;
                logic       rsvd;
                page_size_e page_size;
                nand_op_e   op;
        } nfcr_t;

        typedef struct packed {
                logic cle;
                logic ale;
                logic ce_n;
                logic re_n;
                logic we_n;
        } nand_pins_t;

        //////////////////////////////////////////////////
        // command set
        //////////////////////////////////////////////////

        localparam nand_byte_t CMD_RESET         = 8'hFF;
        localparam nand_byte_t CMD_READ_ID       = 8'h90;
        localparam nand_byte_t CMD_READ_STATUS   = 8'h70;
        localparam nand_byte_t CMD_ERASE_SETUP   = 8'h60;
        localparam nand_byte_t CMD_ERASE_CONFIRM = 8'hD0;

        // clocks per phase
        localparam tick_cnt_t DEF_T_WP  = 8'd2;  // we low width
        localparam tick_cnt_t DEF_T_WC  = 8'd3;  // write cycle
        localparam tick_cnt_t DEF_T_RP  = 8'd2;  // re low width
        localparam tick_cnt_t DEF_T_REH = 8'd1;  // re high hold
        localparam tick_cnt_t DEF_T_WB  = 8'd10; // we high to busy

endpackage

// File: src/nand_read_cycle.sv
`timescale 1ns/1ps

module nand_read_cycle #(
        parameter nand_pkg::tick_cnt_t t_rp  = nand_pkg::DEF_T_RP,
        parameter nand_pkg::tick_cnt_t t_reh = nand_pkg::DEF_T_REH
) (
        input  logic                 clk,
        input  logic                 counter_rst,
        input  logic                 go,
        input  nand_pkg::nand_byte_t read_flash,
        output logic                 ack,
        output nand_pkg::nand_byte_t data,
        output logic                 re_n
);
        import nand_pkg::*;

        localparam tick_cnt_t t_end = t_rp + t_reh;

        tick_cnt_t cnt;
        logic      active;

        always_ff @(posedge clk) begin
                if (counter_rst) begin
                        cnt    <= '0;
                        active <= 1'b0;
                        ack    <= 1'b0;
                        data   <= '0;
                        re_n   <= 1'b1;
                end else begin
                        ack <= 1'b0;
                        if (go) begin
                                active <= 1'b1;
                                cnt    <= 8'd1;
                                re_n   <= 1'b0;
                        end else if (active) begin
                                cnt <= cnt + 8'd1;
                                if (cnt == t_rp) begin
                                        re_n <= 1'b1;
                                        data <= read_flash;     // last low clock
                                end
                                if (cnt == t_end) begin
                                        active <= 1'b0;
                                        ack    <= 1'b1;
                                end
                        end
                end
        end

        // re low only inside a read
        a_re_in_read: assert property (@(posedge clk) disable iff (counter_rst)
                !re_n |-> active);

endmodule

// File: src/nand_sequencer.sv
`timescale 1ns/1ps

module nand_sequencer (
        input  logic                 clk,
        input  logic                 counter_rst,
        input  nand_pkg::nfcr_t      nfcr,
        input  nand_pkg::row_addr_t  nf_addr,
        output logic                 done,
        output nand_pkg::nand_byte_t status,
        output nand_pkg::flash_id_t  id,
        output logic                 read_flash_en,
        output logic                 ce_n,
        output logic                 wr_go,
        output nand_pkg::nand_byte_t wr_byte,
        output logic                 wr_is_cmd,
        output logic                 wr_is_addr,
        output logic                 wr_last_addr,
        input  logic                 wr_ack,
        output logic                 rd_go,
        input  logic                 rd_ack,
        input  nand_pkg::nand_byte_t rd_byte,
        output logic                 busy_go,
        input  logic                 busy_ack
);
        import nand_pkg::*;

        typedef enum logic [2:0] {
                st_idle, st_flash_reset, st_read_id, st_read_status, st_erase
        } seq_state_e;

        // what the current step asks for
        typedef enum logic [2:0] {
                k_cmd, k_addr, k_last_addr, k_read, k_busy, k_done
        } step_kind_e;

        seq_state_e state;
        logic [3:0] step;
        logic       issued;     // go sent, waiting for ack
        logic       large_pg;
        step_kind_e kind;
        nand_byte_t step_byte;
        nand_byte_t row0, row1, row2;

        //////////////////////////////////////////////////
        // erase row address bytes
        //////////////////////////////////////////////////

        assign row0 = large_pg ? nf_addr[19:12] : nf_addr[16:9];
        assign row1 = large_pg ? nf_addr[27:20] : nf_addr[24:17];
        assign row2 = large_pg ? {5'b0, nf_addr[30:28]} : {7'b0, nf_addr[25]};

        //////////////////////////////////////////////////
        // step decode
        //////////////////////////////////////////////////

        always_comb begin
                kind      = k_done;
                step_byte = '0;
                case (state)
                st_flash_reset: case (step)
                        4'd0: begin kind = k_cmd; step_byte = CMD_RESET; end
                        4'd1: kind = k_busy;
                        default: kind = k_done;
                endcase
                st_read_id: case (step)
                        4'd0: begin kind = k_cmd; step_byte = CMD_READ_ID; end
                        4'd1: kind = k_last_addr;       // address 00
                        4'd2, 4'd3, 4'd4, 4'd5, 4'd6: kind = k_read;
                        default: kind = k_done;
                endcase
                st_read_status: case (step)
                        4'd0: begin kind = k_cmd; step_byte = CMD_READ_STATUS; end
                        4'd1: kind = k_read;
                        default: kind = k_done;
                endcase
                st_erase: case (step)
                        4'd0: begin kind = k_cmd; step_byte = CMD_ERASE_SETUP; end
                        4'd1: begin kind = k_addr; step_byte = row0; end
                        4'd2: begin kind = k_addr; step_byte = row1; end
                        4'd3: begin kind = k_last_addr; step_byte = row2; end
                        4'd4: begin kind = k_cmd; step_byte = CMD_ERASE_CONFIRM; end
                        4'd5: kind = k_busy;
                        4'd6: begin kind = k_cmd; step_byte = CMD_READ_STATUS; end
                        4'd7: kind = k_read;
                        default: kind = k_done;
                endcase
                default: kind = k_done;
                endcase
        end

        //////////////////////////////////////////////////
        // operation FSM
        //////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (counter_rst) begin
                        state         <= st_idle;
                        step          <= '0;
                        issued        <= 1'b0;
                        large_pg      <= 1'b0;
                        done          <= 1'b0;
                        status        <= '0;
                        id            <= '0;
                        read_flash_en <= 1'b1;
                        ce_n          <= 1'b1;
                        wr_go         <= 1'b0;
                        wr_byte       <= '0;
                        wr_is_cmd     <= 1'b0;
                        wr_is_addr    <= 1'b0;
                        wr_last_addr  <= 1'b0;
                        rd_go         <= 1'b0;
                        busy_go       <= 1'b0;
                end else begin
                        wr_go   <= 1'b0;
                        rd_go   <= 1'b0;
                        busy_go <= 1'b0;
                        done    <= 1'b0;
                        ce_n    <= 1'b0;        // single chip, always selected
                        if (state == st_idle) begin
                                read_flash_en <= 1'b1;
                                step          <= '0;
                                issued        <= 1'b0;
                                if (nfcr.start && !done) begin
                                        large_pg <= (nfcr.page_size == ps_2k);
                                        case (nfcr.op)
                                        op_reset:       state <= st_flash_reset;
                                        op_read_id:     state <= st_read_id;
                                        op_read_status: state <= st_read_status;
                                        op_erase:       state <= st_erase;
                                        default:        state <= st_idle;
                                        endcase
                                end
                        end else if (!issued) begin
                                issued <= 1'b1;
                                case (kind)
                                k_cmd, k_addr, k_last_addr: begin
                                        wr_go         <= 1'b1;
                                        read_flash_en <= 1'b0;  // drive the bus
                                        wr_byte       <= step_byte;
                                        wr_is_cmd     <= (kind == k_cmd);
                                        wr_is_addr    <= (kind != k_cmd);
                                        wr_last_addr  <= (kind == k_last_addr);
                                end
                                k_read: begin
                                        rd_go         <= 1'b1;
                                        read_flash_en <= 1'b1;
                                end
                                k_busy: busy_go <= 1'b1;
                                default: begin
                                        done  <= 1'b1;
                                        state <= st_idle;
                                end
                                endcase
                        end else if (wr_ack || rd_ack || busy_ack) begin
                                issued <= 1'b0;
                                step   <= step + 4'd1;
                                if (rd_ack) begin
                                        if (state == st_read_id)
                                                id <= {id[31:0], rd_byte};
                                        else
                                                status <= rd_byte;
                                end
                        end
                end
        end

        a_done_pulse: assert property (@(posedge clk) disable iff (counter_rst)
                done |=> !done);

endmodule

// File: src/nand_write_cycle.sv
`timescale 1ns/1ps

module nand_write_cycle #(
        parameter nand_pkg::tick_cnt_t t_wp = nand_pkg::DEF_T_WP,
        parameter nand_pkg::tick_cnt_t t_wc = nand_pkg::DEF_T_WC
) (
        input  logic                 clk,
        input  logic                 counter_rst,
        input  logic                 go,
        input  nand_pkg::nand_byte_t byte_in,
        input  logic                 is_cmd,
        input  logic                 is_addr,
        input  logic                 last_addr,
        output logic                 ack,
        output logic                 cle,
        output logic                 ale,
        output logic                 we_n,
        output nand_pkg::nand_byte_t write_flash
);
        import nand_pkg::*;

        tick_cnt_t cnt;
        logic      active;
        logic      last_q;      // drop ale at the end of this byte

        always_ff @(posedge clk) begin
                if (counter_rst) begin
                        cnt         <= '0;
                        active      <= 1'b0;
                        last_q      <= 1'b0;
                        ack         <= 1'b0;
                        cle         <= 1'b0;
                        ale         <= 1'b0;
                        we_n        <= 1'b1;
                        write_flash <= '0;
                end else begin
                        ack <= 1'b0;
                        if (go) begin
                                active      <= 1'b1;
                                cnt         <= 8'd1;
                                write_flash <= byte_in;
                                cle         <= is_cmd;
                                ale         <= is_addr;
                                last_q      <= last_addr;
                                we_n        <= 1'b0;
                        end else if (active) begin
                                cnt <= cnt + 8'd1;
                                if (cnt == t_wp)
                                        we_n <= 1'b1;   // flash latches on this edge
                                if (cnt == t_wc) begin
                                        active <= 1'b0;
                                        ack    <= 1'b1;
                                        cle    <= 1'b0;
                                        if (last_q)
                                                ale <= 1'b0;
                                end
                        end
                end
        end

        a_cle_ale_excl: assert property (@(posedge clk) disable iff (counter_rst)
                !(cle && ale));

endmodule

// File: testbench/nand_flash_model.sv
`timescale 1ns/1ps

module nand_flash_model (
        input  logic                 clk,
        input  nand_pkg::nand_pins_t pins,
        input  nand_pkg::nand_byte_t write_flash,
        input  nand_pkg::nand_byte_t serve [0:63],    // bytes handed out by reads
        input  int                   busy_len,         // clocks of busy after FF or D0
        output nand_pkg::nand_byte_t read_flash,
        output logic                 r,
        output logic [9:0]           log_mem [0:63],   // {cle, ale, byte}
        output int                   log_cnt,
        output int                   rd_cnt
);
        import nand_pkg::*;

        int cyc = 0;
        int busy_until = 0;
        int n_logged = 0;
        int n_read = 0;

        assign log_cnt = n_logged;
        assign rd_cnt  = n_read;

        //////////////////////////////////////////////////
        // ready/busy
        //////////////////////////////////////////////////

        always @(posedge clk)
                cyc <= cyc + 1;

        assign r = (cyc >= busy_until);

        //////////////////////////////////////////////////
        // command and address latch
        //////////////////////////////////////////////////

        // cle and ale are still valid on the rising we edge
        always @(posedge pins.we_n) begin
                if (!pins.ce_n && (pins.cle || pins.ale)) begin  // deselected chip ignores we
                        log_mem[n_logged[5:0]] = {pins.cle, pins.ale, write_flash};
                        n_logged = n_logged + 1;
                        if (pins.cle && (write_flash == CMD_RESET ||
                                         write_flash == CMD_ERASE_CONFIRM))
                                busy_until = cyc + busy_len;    // start of the busy time
                end
        end

        // data out only while re is low
        assign read_flash = pins.re_n ? 8'h00 : serve[n_read[5:0]];

        always begin
                @(negedge pins.re_n);
                @(posedge pins.re_n);
                n_read = n_read + 1;    // next read gets the next byte
        end

endmodule

// File: testbench/tb_nand_controller.sv
`timescale 1ns/1ps

module tb_nand_controller;
        import nand_pkg::*;

        localparam int TIMEOUT_CLKS = 1000;
        localparam int RESET_BUSY   = 40;       // clocks of r low after FF
        localparam int ERASE_BUSY   = 25;

        logic        clk;
        logic        counter_rst;
        nfcr_t       nfcr;
        row_addr_t   nf_addr;
        logic        r;
        nand_byte_t  read_flash;
        nand_byte_t  write_flash;
        nand_byte_t  status;
        flash_id_t   id;
        nand_pins_t  pins;
        logic        done;
        logic        read_flash_en;
        nand_byte_t  serve [0:63];
        logic [9:0]  log_mem [0:63];
        int          busy_len;
        int          log_cnt;
        int          rd_cnt;
        int          log_base;
        logic [31:0] lfsr = 32'h31f94123;
        string       test_name;
        int          test_errors = 0;
        int          errors = 0;
        int          tests_run = 0;
        int          tests_failed = 0;

        nand_controller nand_controller_inst (
                .clk(clk), .counter_rst(counter_rst), .nfcr(nfcr), .nf_addr(nf_addr),
                .r(r), .read_flash(read_flash), .done(done), .status(status), .id(id),
                .pins(pins), .write_flash(write_flash), .read_flash_en(read_flash_en)
        );

        nand_flash_model flash_inst (
                .clk(clk), .pins(pins), .write_flash(write_flash), .serve(serve),
                .busy_len(busy_len), .read_flash(read_flash), .r(r),
                .log_mem(log_mem), .log_cnt(log_cnt), .rd_cnt(rd_cnt)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        //////////////////////////////////////////////////
        // helpers
        //////////////////////////////////////////////////

        // taps 32 22 2 1
        function automatic logic [31:0] lfsr_step(logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [31:0] rand_bits(int n);
                logic [31:0] v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsr_step(lfsr);
                        v = {v[30:0], lfsr[0]};         // one step per bit
                end
                return v;
        endfunction

        task automatic check(string what, logic [39:0] expected, logic [39:0] actual);
                if (expected !== actual) begin
                        $display("** Error %s: %s expected %h actual %h",
                                 test_name, what, expected, actual);
                        test_errors++;
                end
        endtask

        task automatic report_failure(string msg);
                $display("%s: %s", test_name, msg);
                test_errors++;
        endtask

        task automatic next_cycle();
                @(posedge clk);
                #5;                     // drive and sample away from the edge
        endtask

        task automatic begin_test(string name);
                test_name   = name;
                test_errors = 0;
                log_base    = log_cnt;
        endtask

        task automatic end_test();
                tests_run++;
                errors += test_errors;
                if (test_errors == 0) begin
                        $display("%-18s ok", test_name);
                end else begin
                        tests_failed++;
                        $display("%-18s failed, %0d errors", test_name, test_errors);
                end
        endtask

        task automatic launch(nand_op_e op, page_size_e ps);
                nfcr.start     = 1'b1;
                nfcr.op        = op;
                nfcr.page_size = ps;
                next_cycle();
                nfcr.start     = 1'b0;
        endtask

        task automatic wait_done();
                int n = 0;
                while (!done && n < TIMEOUT_CLKS) begin
                        next_cycle();
                        n++;
                end
                if (!done)
                        report_failure("no done pulse before the timeout");
                else
                        next_cycle();   // start is ignored while done is high
        endtask

        task automatic check_log_len(int n);
                check("log length", 40'(n), 40'(log_cnt - log_base));
        endtask

        task automatic check_log(int idx, logic cmd, nand_byte_t b);
                check($sformatf("log byte %0d", idx), 40'({cmd, !cmd, b}),
                      40'(log_mem[6'(log_base + idx)]));
        endtask

        //////////////////////////////////////////////////
        // directed tests
        //////////////////////////////////////////////////

        task automatic test_read_status();
                nand_byte_t b;
                begin_test("read_status");
                b = 8'(rand_bits(8));
                serve[6'(rd_cnt)] = b;
                launch(op_read_status, ps_512);
                wait_done();
                check_log_len(1);
                check_log(0, 1'b1, CMD_READ_STATUS);
                check("status", 40'(b), 40'(status));
                end_test();
        endtask

        task automatic test_read_id();
                flash_id_t  exp = '0;
                nand_byte_t b;
                begin_test("read_id");
                for (int k = 0; k < 5; k++) begin
                        b = 8'(rand_bits(8));
                        serve[6'(rd_cnt + k)] = b;
                        exp[8 * (4 - k) +: 8] = b;      // first byte ends up on top
                end
                launch(op_read_id, ps_2k);
                wait_done();
                check_log_len(2);
                check_log(0, 1'b1, CMD_READ_ID);
                check_log(1, 1'b0, 8'h00);
                check("id", exp, id);
                end_test();
        endtask

        task automatic test_flash_reset();
                int n = 0;
                begin_test("flash_reset");
                busy_len = RESET_BUSY;
                launch(op_reset, ps_256);
                while (r && n < TIMEOUT_CLKS) begin
                        next_cycle();
                        n++;
                end
                if (r)
                        report_failure("ready/busy never went low after FF");
                n = 0;
                while (!r && n < TIMEOUT_CLKS) begin
                        if (done)
                                report_failure("done came while the flash was busy");
                        next_cycle();
                        n++;
                end
                wait_done();
                check_log_len(1);
                check_log(0, 1'b1, CMD_RESET);
                end_test();
        endtask

        task automatic test_erase(string name, page_size_e ps);
                row_addr_t  a;
                nand_byte_t b;
                nand_byte_t row [0:2];
                begin_test(name);
                a = rand_bits(32);
                b = 8'(rand_bits(8));
                if (ps == ps_2k)
                        row = '{a[19:12], a[27:20], {5'b0, a[30:28]}};
                else
                        row = '{a[16:9], a[24:17], {7'b0, a[25]}};
                nf_addr           = a;
                serve[6'(rd_cnt)] = b;
                busy_len          = ERASE_BUSY;
                launch(op_erase, ps);
                wait_done();
                check_log_len(6);
                check_log(0, 1'b1, CMD_ERASE_SETUP);
                for (int i = 0; i < 3; i++)
                        check_log(i + 1, 1'b0, row[2'(i)]);
                check_log(4, 1'b1, CMD_ERASE_CONFIRM);
                check_log(5, 1'b1, CMD_READ_STATUS);
                check("status", 40'(b), 40'(status));
                end_test();
        endtask

        task automatic test_unsupported();
                nand_op_e ops [0:3] = '{op_none, op_program, op_page_read, nand_op_e'(4'd7)};
                begin_test("unsupported_ops");
                foreach (ops[i]) begin
                        launch(ops[i], ps_512);
                        for (int n = 0; n < TIMEOUT_CLKS; n++) begin
                                if (done)
                                        report_failure($sformatf("done came for op %0d", ops[i]));
                                next_cycle();
                        end
                end
                check_log_len(0);
                end_test();
        endtask

        initial begin
                counter_rst = 1'b1;
                nfcr        = '0;
                nf_addr     = '0;
                busy_len    = 0;
                for (int i = 0; i < 64; i++)
                        serve[6'(i)] = 8'(i) ^ 8'h5a;
                begin_test("reset_values");
                repeat (10) next_cycle();
                check("done", 40'(0), 40'(done));
                check("cle ale re_n we_n", 40'(4'b0011),
                      40'({pins.cle, pins.ale, pins.re_n, pins.we_n}));
                check("read_flash_en", 40'(1), 40'(read_flash_en));
                check("status", 40'(0), 40'(status));
                check("id", 40'(0), id);
                counter_rst = 1'b0;
                end_test();

                test_read_status();
                test_read_id();
                test_flash_reset();
                test_erase("erase_large_page", ps_2k);
                test_erase("erase_small_page", ps_512);
                test_unsupported();

                $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
                if (tests_failed == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

endmodule
